// ==== source/ising_params.svh ====
// Ising array sizing
`ifndef ISING_PARAMS_SVH
`define ISING_PARAMS_SVH

// spins with one write wordline each
`define ISING_NUM_SPIN 16
`define ISING_BITDATA 4
// spins per coupling row as a power of two of at least 2
`define ISING_PARALLELISM 4
`define ISING_CNT_W 16

`define ISING_J_ROWS (`ISING_NUM_SPIN / `ISING_PARALLELISM)
`define ISING_J_AW ((`ISING_J_ROWS > 1) ? $clog2(`ISING_J_ROWS) : 1)

`define ISING_REG_AW 2

`endif

// ==== source/ising_cfg_pkg.sv ====
// Register side types
`include "ising_params.svh"

package ising_cfg_pkg;

    // wordline pulse timing in clock cycles
    typedef struct packed {
        logic [`ISING_CNT_W-1:0] wwl_high;
        logic [`ISING_CNT_W-1:0] wwl_low;
    } timing_cfg_t;

    typedef enum logic [`ISING_REG_AW-1:0] {
        CTRL     = 'd0,
        WWL_HIGH = 'd1,
        WWL_LOW  = 'd2,
        STATUS   = 'd3
    } reg_addr_e;

endpackage

// ==== source/analog_if_pkg.sv ====
// Analog array side types
`include "ising_params.svh"

package analog_if_pkg;

    // bitline data for one wordline write
    typedef logic [`ISING_NUM_SPIN*`ISING_BITDATA-1:0] bl_word_t;

    // slice k belongs to spin row*PARALLELISM + k
    typedef bl_word_t [`ISING_PARALLELISM-1:0] j_row_t;

    typedef bl_word_t h_vec_t;

    typedef struct packed {
        logic [`ISING_NUM_SPIN-1:0] j_wwl;
        logic                       h_wwl;
        bl_word_t                   wbl;
    } macro_drive_t;

endpackage

// ==== source/step_counter.sv ====
// Loadable step counter
`timescale 1ns/10ps

module step_counter #(
    parameter int WIDTH = 16
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             clear_i,
    input  logic             step_i,
    input  logic [WIDTH-1:0] limit_i,
    output logic [WIDTH-1:0] count_o,
    output logic             at_limit_o
);

    logic [WIDTH-1:0] count_q;
    logic [WIDTH-1:0] count_inc;

    assign count_inc = count_q + 1'b1;

    // last stepping cycle of the phase
    assign at_limit_o = step_i && (count_inc == limit_i);
    assign count_o    = count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (step_i) begin
            count_q <= count_inc;
        end
    end

endmodule

// ==== source/cfg_regs.sv ====
// Configuration register block
`timescale 1ns/10ps
`include "ising_params.svh"

module cfg_regs (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       reg_we_i,
    input  logic [`ISING_REG_AW-1:0]   reg_addr_i,
    input  logic [31:0]                reg_wdata_i,
    output logic [31:0]                reg_rdata_o,
    input  logic                       idle_i,
    output logic                       en_o,
    output logic                       start_o,
    output ising_cfg_pkg::timing_cfg_t timing_o
);

    logic                       en_q;
    logic                       start_q;
    ising_cfg_pkg::timing_cfg_t timing_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q              <= 1'b0;
            start_q           <= 1'b0;
            timing_q.wwl_high <= 'd1;
            timing_q.wwl_low  <= 'd1;
        end else begin
            // start lasts a single cycle
            start_q <= 1'b0;
            if (reg_we_i) begin
                case (ising_cfg_pkg::reg_addr_e'(reg_addr_i))
                    ising_cfg_pkg::CTRL: begin
                        en_q    <= reg_wdata_i[0];
                        start_q <= reg_wdata_i[1];
                    end
                    ising_cfg_pkg::WWL_HIGH: begin
                        timing_q.wwl_high <= reg_wdata_i[`ISING_CNT_W-1:0];
                    end
                    ising_cfg_pkg::WWL_LOW: begin
                        timing_q.wwl_low <= reg_wdata_i[`ISING_CNT_W-1:0];
                    end
                    default: begin
                        // status is read only
                    end
                endcase
            end
        end
    end

    always_comb begin
        reg_rdata_o = '0;
        case (ising_cfg_pkg::reg_addr_e'(reg_addr_i))
            ising_cfg_pkg::CTRL:     reg_rdata_o[0] = en_q;
            ising_cfg_pkg::WWL_HIGH: reg_rdata_o[`ISING_CNT_W-1:0] = timing_q.wwl_high;
            ising_cfg_pkg::WWL_LOW:  reg_rdata_o[`ISING_CNT_W-1:0] = timing_q.wwl_low;
            ising_cfg_pkg::STATUS:   reg_rdata_o[0] = idle_i;
            default:                 reg_rdata_o = '0;
        endcase
    end

    assign en_o     = en_q;
    assign start_o  = start_q;
    assign timing_o = timing_q;

endmodule

// ==== source/coupling_mem.sv ====
// Register based coupling memory
`timescale 1ns/10ps

module coupling_mem #(
    parameter type word_t = logic [31:0],
    parameter int DEPTH = 4,
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk_i,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  word_t         wdata_i,
    input  logic          re_i,
    input  logic [AW-1:0] raddr_i,
    output word_t         rdata_o
);

    word_t mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data holds until the next read
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

// ==== source/analog_cfg.sv ====
// Wordline and bitline sequencer
`timescale 1ns/10ps
`include "ising_params.svh"

module analog_cfg (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic                        start_i,
    input  ising_cfg_pkg::timing_cfg_t  timing_i,
    output logic                        j_ren_o,
    output logic [`ISING_J_AW-1:0]      j_raddr_o,
    input  analog_if_pkg::j_row_t       j_rdata_i,
    output logic                        h_ren_o,
    input  analog_if_pkg::h_vec_t       h_rdata_i,
    output analog_if_pkg::macro_drive_t macro_o,
    output logic                        idle_o
);

    localparam int SEL_W = $clog2(`ISING_PARALLELISM);
    localparam int SPIN_W = $clog2(`ISING_NUM_SPIN + 2);
    // spin index NUM_SPIN is the h step
    localparam logic [SPIN_W-1:0] H_SPIN = SPIN_W'(`ISING_NUM_SPIN);
    localparam logic [SPIN_W-1:0] SPIN_LIMIT = SPIN_W'(`ISING_NUM_SPIN + 1);

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_HIGH,
        PH_LOW
    } phase_e;

    phase_e                      phase_q;
    logic                        busy_q;
    logic                        last_q;
    logic                        wbl_ld_q;
    logic                        start_go;
    logic                        high_step;
    logic                        low_step;
    logic                        high_done;
    logic                        low_done;
    logic                        go_high;
    logic                        finish;
    logic                        row_fetch;
    logic                        slice_adv;
    logic                        spin_at_limit;
    logic [SPIN_W-1:0]           spin_cnt;
    logic [SPIN_W-1:0]           nxt_spin;
    logic [SPIN_W-1:0]           rd_spin;
    analog_if_pkg::bl_word_t     wbl_nxt;
    analog_if_pkg::macro_drive_t macro_q;

    assign start_go  = en_i && start_i && !busy_q;
    assign high_step = busy_q && (phase_q == PH_HIGH);
    assign low_step  = busy_q && (phase_q == PH_LOW);
    assign go_high   = busy_q && ((phase_q == PH_FETCH) || (low_done && !last_q));
    assign finish    = low_done && last_q;

    // fetch for the next spin is issued on the last high cycle
    assign nxt_spin  = spin_cnt + 1'b1;
    assign rd_spin   = busy_q ? nxt_spin : '0;
    assign row_fetch = high_done && (nxt_spin < H_SPIN) && (nxt_spin[SEL_W-1:0] == '0);
    assign slice_adv = high_done && (nxt_spin < H_SPIN) && (nxt_spin[SEL_W-1:0] != '0);

    assign j_ren_o   = en_i && (start_go || row_fetch);
    assign j_raddr_o = rd_spin[SEL_W +: `ISING_J_AW];
    assign h_ren_o   = en_i && high_done && (nxt_spin == H_SPIN);

    assign wbl_nxt = (spin_cnt == H_SPIN) ? h_rdata_i : j_rdata_i[spin_cnt[SEL_W-1:0]];

    assign idle_o  = !busy_q;
    assign macro_o = macro_q;

    step_counter #(
        .WIDTH (`ISING_CNT_W)
    ) u_high_timer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (!busy_q || high_done),
        .step_i     (high_step),
        .limit_i    (timing_i.wwl_high),
        .count_o    (),
        .at_limit_o (high_done)
    );

    step_counter #(
        .WIDTH (`ISING_CNT_W)
    ) u_low_timer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (!busy_q || low_done),
        .step_i     (low_step),
        .limit_i    (timing_i.wwl_low),
        .count_o    (),
        .at_limit_o (low_done)
    );

    // advances at the end of every pulse including h
    step_counter #(
        .WIDTH (SPIN_W)
    ) u_spin_idx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .clear_i    (!busy_q),
        .step_i     (high_done),
        .limit_i    (SPIN_LIMIT),
        .count_o    (spin_cnt),
        .at_limit_o (spin_at_limit)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            phase_q <= PH_FETCH;
        end else if (!en_i) begin
            busy_q  <= 1'b0;
            phase_q <= PH_FETCH;
        end else if (start_go) begin
            busy_q  <= 1'b1;
            phase_q <= PH_FETCH;
        end else if (busy_q) begin
            case (phase_q)
                PH_FETCH: phase_q <= PH_HIGH;
                PH_HIGH: begin
                    if (high_done) begin
                        phase_q <= PH_LOW;
                    end
                end
                PH_LOW: begin
                    if (finish) begin
                        busy_q  <= 1'b0;
                        phase_q <= PH_FETCH;
                    end else if (low_done) begin
                        phase_q <= PH_HIGH;
                    end
                end
                default: phase_q <= PH_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_q   <= 1'b0;
            wbl_ld_q <= 1'b0;
        end else begin
            // bitlines follow one cycle after a fetch or slice advance
            wbl_ld_q <= j_ren_o || h_ren_o || (en_i && slice_adv);
            if (!busy_q) begin
                last_q <= 1'b0;
            end else if (spin_at_limit) begin
                last_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            macro_q <= '0;
        end else if (!en_i || finish) begin
            macro_q <= '0;
        end else begin
            if (wbl_ld_q) begin
                macro_q.wbl <= wbl_nxt;
            end
            if (go_high) begin
                macro_q.j_wwl <= (spin_cnt < H_SPIN) ? (`ISING_NUM_SPIN'(1) << spin_cnt) : '0;
                macro_q.h_wwl <= (spin_cnt == H_SPIN);
            end else if (high_done) begin
                macro_q.j_wwl <= '0;
                macro_q.h_wwl <= 1'b0;
            end
        end
    end

endmodule

// ==== source/ising_cfg_top.sv ====
// Ising configuration path top
`timescale 1ns/10ps
`include "ising_params.svh"

module ising_cfg_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        reg_we_i,
    input  logic [`ISING_REG_AW-1:0]    reg_addr_i,
    input  logic [31:0]                 reg_wdata_i,
    output logic [31:0]                 reg_rdata_o,
    input  logic                        j_we_i,
    input  logic [`ISING_J_AW-1:0]      j_waddr_i,
    input  analog_if_pkg::j_row_t       j_wdata_i,
    input  logic                        h_we_i,
    input  analog_if_pkg::h_vec_t       h_wdata_i,
    output analog_if_pkg::macro_drive_t macro_o,
    output logic                        idle_o
);

    logic                       en;
    logic                       start;
    ising_cfg_pkg::timing_cfg_t timing;
    logic                       j_ren;
    logic [`ISING_J_AW-1:0]     j_raddr;
    analog_if_pkg::j_row_t      j_rdata;
    logic                       h_ren;
    analog_if_pkg::h_vec_t      h_rdata;

    cfg_regs u_cfg_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .idle_i      (idle_o),
        .en_o        (en),
        .start_o     (start),
        .timing_o    (timing)
    );

    coupling_mem #(
        .word_t (analog_if_pkg::j_row_t),
        .DEPTH  (`ISING_J_ROWS)
    ) u_j_mem (
        .clk_i   (clk_i),
        .we_i    (j_we_i),
        .waddr_i (j_waddr_i),
        .wdata_i (j_wdata_i),
        .re_i    (j_ren),
        .raddr_i (j_raddr),
        .rdata_o (j_rdata)
    );

    // single bias word
    coupling_mem #(
        .word_t (analog_if_pkg::h_vec_t),
        .DEPTH  (1)
    ) u_h_mem (
        .clk_i   (clk_i),
        .we_i    (h_we_i),
        .waddr_i (1'b0),
        .wdata_i (h_wdata_i),
        .re_i    (h_ren),
        .raddr_i (1'b0),
        .rdata_o (h_rdata)
    );

    analog_cfg u_analog_cfg (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .en_i      (en),
        .start_i   (start),
        .timing_i  (timing),
        .j_ren_o   (j_ren),
        .j_raddr_o (j_raddr),
        .j_rdata_i (j_rdata),
        .h_ren_o   (h_ren),
        .h_rdata_i (h_rdata),
        .macro_o   (macro_o),
        .idle_o    (idle_o)
    );

endmodule

// ==== test/tb_ising_cfg.sv ====
// Ising configuration path testbench
`timescale 1ns/10ps
`include "ising_params.svh"

module tb_ising_cfg;

    // pulse cycles of all passes with (1,1) once and (3,2) three times
    localparam int PULSE_CYCLES = (`ISING_NUM_SPIN + 1) * ((1 + 1) + 3 * (3 + 2));
    localparam int WATCHDOG_NS  = (2 * PULSE_CYCLES + 300) * 20;

    logic                          clk;
    logic                          rst_n;
    logic                          reg_we;
    logic [`ISING_REG_AW-1:0]      reg_addr;
    logic [31:0]                   reg_wdata;
    logic [31:0]                   reg_rdata;
    logic                          j_we;
    logic [`ISING_J_AW-1:0]        j_waddr;
    analog_if_pkg::j_row_t         j_wdata;
    logic                          h_we;
    analog_if_pkg::h_vec_t         h_wdata;
    analog_if_pkg::macro_drive_t   macro;
    logic                          idle;
    logic [15:0]                   lfsr_q;
    logic [31:0]                   rd;
    // scoreboard of written memory contents
    analog_if_pkg::j_row_t         j_model [`ISING_J_ROWS];
    analog_if_pkg::h_vec_t         h_model;

    ising_cfg_top dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .reg_we_i    (reg_we),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .j_we_i      (j_we),
        .j_waddr_i   (j_waddr),
        .j_wdata_i   (j_wdata),
        .h_we_i      (h_we),
        .h_wdata_i   (h_wdata),
        .macro_o     (macro),
        .idle_o      (idle)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got_v);
        assert (got_v == exp_v)
        else abort_run($sformatf("FAIL %s exp %h got %h", name, exp_v, got_v));
    endtask

    a_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(macro.j_wwl))
        else abort_run("more than one j wordline is high");
    a_excl: assert property (@(posedge clk) disable iff (!rst_n) !(macro.h_wwl && |macro.j_wwl))
        else abort_run("h wordline and a j wordline are high together");
    a_abort: assert property (@(posedge clk) disable iff (!rst_n)
                              !dut.en |=> (macro == '0 && idle))
        else abort_run("outputs not cleared and idle not set one cycle after enable dropped");
    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
                             (dut.start && dut.en && idle) |=> !idle)
        else abort_run("idle did not fall on the cycle after start");

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [63:0] w);
        for (int i = 0; i < 64; i++) begin
            w[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic write_reg(input logic [`ISING_REG_AW-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_we    = 1'b0;
    endtask

    task automatic read_reg(input logic [`ISING_REG_AW-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        reg_addr = addr;
        #2;
        data = reg_rdata;
    endtask

    task automatic load_memories();
        analog_if_pkg::j_row_t row;
        logic [63:0]           w;
        for (int r = 0; r < `ISING_J_ROWS; r++) begin
            for (int k = 0; k < `ISING_PARALLELISM; k++) begin
                rand_word(w);
                row[k] = w;
            end
            j_model[r] = row;
            @(negedge clk);
            j_we    = 1'b1;
            j_waddr = r[`ISING_J_AW-1:0];
            j_wdata = row;
        end
        rand_word(w);
        h_model = w;
        @(negedge clk);
        j_we    = 1'b0;
        h_we    = 1'b1;
        h_wdata = w;
        @(negedge clk);
        h_we    = 1'b0;
    endtask

    // check one sampled cycle, then move to the next falling edge
    task automatic expect_cycle(input logic [`ISING_NUM_SPIN-1:0] wwl_e, input logic h_e,
                                input logic wbl_chk, input logic [63:0] wbl_e,
                                input logic idle_e);
        check_val("j_wwl", 64'(wwl_e), 64'(macro.j_wwl));
        check_val("h_wwl", 64'(h_e), 64'(macro.h_wwl));
        if (wbl_chk) begin
            check_val("wbl", wbl_e, 64'(macro.wbl));
        end
        check_val("idle_o", 64'(idle_e), 64'(idle));
        @(negedge clk);
    endtask

    task automatic wait_first_wordline();
        int waited;
        waited = 0;
        while (macro.j_wwl == '0) begin
            if (waited == 6) begin
                abort_run("first wordline did not rise within 6 cycles of start");
            end
            expect_cycle('0, 1'b0, 1'b0, '0, 1'b0);
            waited++;
        end
    endtask

    task automatic run_pass(input int high, input int low);
        logic [`ISING_NUM_SPIN-1:0] one_hot;
        write_reg(ising_cfg_pkg::WWL_HIGH, 32'(high));
        write_reg(ising_cfg_pkg::WWL_LOW, 32'(low));
        write_reg(ising_cfg_pkg::CTRL, 32'd3);
        @(negedge clk);
        wait_first_wordline();
        for (int s = 0; s < `ISING_NUM_SPIN; s++) begin
            one_hot = {{(`ISING_NUM_SPIN-1){1'b0}}, 1'b1} << s;
            for (int c = 0; c < high; c++) begin
                expect_cycle(one_hot, 1'b0, 1'b1,
                             j_model[s / `ISING_PARALLELISM][s % `ISING_PARALLELISM], 1'b0);
            end
            for (int c = 0; c < low; c++) begin
                expect_cycle('0, 1'b0, 1'b0, '0, 1'b0);
            end
        end
        for (int c = 0; c < high; c++) begin
            expect_cycle('0, 1'b1, 1'b1, h_model, 1'b0);
        end
        for (int c = 0; c < low; c++) begin
            expect_cycle('0, 1'b0, 1'b0, '0, 1'b0);
        end
        expect_cycle('0, 1'b0, 1'b1, '0, 1'b1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout: the passes did not complete in the expected time");
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        j_we      = 1'b0;
        j_waddr   = '0;
        j_wdata   = '0;
        h_we      = 1'b0;
        h_wdata   = '0;
        lfsr_q    = 16'd67;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_val("macro_o.j_wwl", 64'd0, 64'(macro.j_wwl));
        check_val("macro_o.h_wwl", 64'd0, 64'(macro.h_wwl));
        check_val("macro_o.wbl", 64'd0, 64'(macro.wbl));
        read_reg(ising_cfg_pkg::STATUS, rd);
        check_val("status", 64'd1, 64'(rd));
        write_reg(ising_cfg_pkg::WWL_HIGH, 32'd3);
        write_reg(ising_cfg_pkg::WWL_LOW, 32'd2);
        read_reg(ising_cfg_pkg::WWL_HIGH, rd);
        check_val("wwl_high", 64'd3, 64'(rd));
        read_reg(ising_cfg_pkg::WWL_LOW, rd);
        check_val("wwl_low", 64'd2, 64'(rd));

        load_memories();
        run_pass(1, 1);
        run_pass(3, 2);

        // start while disabled must not launch a pass
        write_reg(ising_cfg_pkg::CTRL, 32'd2);
        repeat (10) expect_cycle('0, 1'b0, 1'b1, '0, 1'b1);

        // abort in the middle of a pass
        write_reg(ising_cfg_pkg::CTRL, 32'd3);
        @(negedge clk);
        wait_first_wordline();
        repeat (20) @(negedge clk);
        write_reg(ising_cfg_pkg::CTRL, 32'd0);
        @(negedge clk);
        expect_cycle('0, 1'b0, 1'b1, '0, 1'b1);

        load_memories();
        run_pass(3, 2);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+source
source/ising_cfg_pkg.sv
source/analog_if_pkg.sv
source/step_counter.sv
source/cfg_regs.sv
source/coupling_mem.sv
source/analog_cfg.sv
source/ising_cfg_top.sv
test/tb_ising_cfg.sv

// ==== run.sh ====
#!/bin/sh
# build and run the Ising configuration path simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_ising_cfg -f flist.f -o sim_ising_cfg \
    && ./obj_dir/sim_ising_cfg \
    || exit 1
